/* verilog/core_macros.svh */
// ---------------------------------------------------------------------------
// Core-wide constants. The datapath is only built and checked at 32 bits
// ---------------------------------------------------------------------------

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data and address width
`define CORE_XLEN 32

// Register file size and index width
`define CORE_NREGS 32
`define CORE_REG_AW 5

// Fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

/* verilog/rv_isa_pkg.sv */
// ---------------------------------------------------------------------------
// RV32I instruction set types. Only the opcodes the core executes are listed
// ---------------------------------------------------------------------------

`include "core_macros.svh"

`default_nettype none

package rv_isa_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // Branch funct3, 3'b010 and 3'b011 are reserved
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_t;

endpackage

`default_nettype wire

/* verilog/core_ctrl_pkg.sv */
// ---------------------------------------------------------------------------
// Control selects used inside the core between decoder and datapath
// ---------------------------------------------------------------------------

`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // Immediate formats, S is decoded but no stored instruction uses it
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_t;

    // Write-back source, LINK is PC+4
    typedef enum logic [1:0] {WB_ALU, WB_LINK, WB_TARGET} wb_sel_t;

    typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_BRANCH} pc_sel_t;

endpackage

`default_nettype wire

/* verilog/decode_if.sv */
// ---------------------------------------------------------------------------
// Decoded control bundle. Purely combinational, valid while the instruction
// is presented
// ---------------------------------------------------------------------------

`default_nettype none

interface decode_if;

    core_ctrl_pkg::alu_op_t alu_op;
    logic alu_src_imm;
    rv_isa_pkg::word_t imm;
    core_ctrl_pkg::wb_sel_t wb_sel;
    core_ctrl_pkg::pc_sel_t pc_sel;
    rv_isa_pkg::branch_cond_t branch_cond;
    logic target_from_rs1;
    logic reg_write;
    logic illegal;

    modport ctrl (
        output alu_op, alu_src_imm, imm, wb_sel, pc_sel,
               branch_cond, target_from_rs1, reg_write, illegal
    );

    modport exec (input alu_op, alu_src_imm, imm, branch_cond, target_from_rs1);

    modport commit (input wb_sel, pc_sel, reg_write, illegal);

endinterface

`default_nettype wire

/* verilog/instr_decoder.sv */
// ---------------------------------------------------------------------------
// Control unit and immediate generation. Unknown opcodes decode to a
// non-writing instruction flagged illegal
// ---------------------------------------------------------------------------

`default_nettype none

module instr_decoder (
    input  rv_isa_pkg::instr_t i_instr,
    decode_if.ctrl             dec
);

    rv_isa_pkg::opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_ctrl_pkg::imm_sel_t imm_sel;
    core_ctrl_pkg::alu_op_t arith_op;

    assign opcode = rv_isa_pkg::opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign dec.branch_cond = rv_isa_pkg::branch_cond_t'(funct3);

    // Shared by OP and OP_IMM, SUB only exists in register form
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == rv_isa_pkg::OPC_OP && funct7[5]) ?
                                core_ctrl_pkg::ALU_SUB : core_ctrl_pkg::ALU_ADD;
            3'b001:  arith_op = core_ctrl_pkg::ALU_SLL;
            3'b010:  arith_op = core_ctrl_pkg::ALU_SLT;
            3'b011:  arith_op = core_ctrl_pkg::ALU_SLTU;
            3'b100:  arith_op = core_ctrl_pkg::ALU_XOR;
            3'b101:  arith_op = funct7[5] ? core_ctrl_pkg::ALU_SRA : core_ctrl_pkg::ALU_SRL;
            3'b110:  arith_op = core_ctrl_pkg::ALU_OR;
            default: arith_op = core_ctrl_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec.alu_op          = core_ctrl_pkg::ALU_ADD;
        dec.alu_src_imm     = 1'b1;
        dec.wb_sel          = core_ctrl_pkg::WB_ALU;
        dec.pc_sel          = core_ctrl_pkg::PC_SEQ;
        dec.target_from_rs1 = 1'b0;
        dec.reg_write       = 1'b0;
        dec.illegal         = 1'b0;
        imm_sel             = core_ctrl_pkg::IMM_I;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                dec.alu_src_imm = 1'b0;
                dec.alu_op      = arith_op;
                dec.reg_write   = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                dec.alu_op    = arith_op;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                imm_sel       = core_ctrl_pkg::IMM_U;
                dec.alu_op    = core_ctrl_pkg::ALU_PASS_B;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                imm_sel       = core_ctrl_pkg::IMM_U;
                dec.wb_sel    = core_ctrl_pkg::WB_TARGET;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                imm_sel       = core_ctrl_pkg::IMM_J;
                dec.wb_sel    = core_ctrl_pkg::WB_LINK;
                dec.pc_sel    = core_ctrl_pkg::PC_JUMP;
                dec.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                dec.wb_sel          = core_ctrl_pkg::WB_LINK;
                dec.pc_sel          = core_ctrl_pkg::PC_JUMP;
                dec.target_from_rs1 = 1'b1;
                dec.reg_write       = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                imm_sel    = core_ctrl_pkg::IMM_B;
                dec.pc_sel = core_ctrl_pkg::PC_BRANCH;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

    // Sign extension from bit 31 for every format
    always_comb begin
        case (imm_sel)
            core_ctrl_pkg::IMM_S: dec.imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            core_ctrl_pkg::IMM_B: dec.imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                                             i_instr[30:25], i_instr[11:8], 1'b0};
            core_ctrl_pkg::IMM_U: dec.imm = {i_instr[31:12], 12'b0};
            core_ctrl_pkg::IMM_J: dec.imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                                             i_instr[20], i_instr[30:21], 1'b0};
            default:              dec.imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

    illegal_never_writes: assert final (!(dec.illegal && dec.reg_write));

endmodule

`default_nettype wire

/* verilog/regfile.sv */
// ---------------------------------------------------------------------------
// Register file, two combinational reads and one write at the clock edge.
// A read of the register being written returns the old value
// ---------------------------------------------------------------------------

`include "core_macros.svh"

`default_nettype none

module regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::reg_addr_t i_rs1_addr,
    input  rv_isa_pkg::reg_addr_t i_rs2_addr,
    output rv_isa_pkg::word_t     o_rs1_data,
    output rv_isa_pkg::word_t     o_rs2_data,
    input  logic                  i_we,
    input  rv_isa_pkg::reg_addr_t i_rd_addr,
    input  rv_isa_pkg::word_t     i_rd_data
);

    // x0 has no storage
    rv_isa_pkg::word_t regs [1:`CORE_NREGS-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (i_rs1_addr == '0) |-> (o_rs1_data == '0));

endmodule

`default_nettype wire

/* verilog/alu.sv */
// ---------------------------------------------------------------------------
// Integer ALU. Shift amounts use the low five bits of operand B
// ---------------------------------------------------------------------------

`default_nettype none

module alu (
    decode_if.exec            dec,
    input  rv_isa_pkg::word_t i_rs1_data,
    input  rv_isa_pkg::word_t i_rs2_data,
    output rv_isa_pkg::word_t o_result
);

    rv_isa_pkg::word_t op_b;
    logic [4:0] shamt;

    assign op_b  = dec.alu_src_imm ? dec.imm : i_rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            core_ctrl_pkg::ALU_ADD:    o_result = i_rs1_data + op_b;
            core_ctrl_pkg::ALU_SUB:    o_result = i_rs1_data - op_b;
            core_ctrl_pkg::ALU_SLL:    o_result = i_rs1_data << shamt;
            core_ctrl_pkg::ALU_SLT:
                o_result = rv_isa_pkg::word_t'($signed(i_rs1_data) < $signed(op_b));
            core_ctrl_pkg::ALU_SLTU:   o_result = rv_isa_pkg::word_t'(i_rs1_data < op_b);
            core_ctrl_pkg::ALU_XOR:    o_result = i_rs1_data ^ op_b;
            core_ctrl_pkg::ALU_SRL:    o_result = i_rs1_data >> shamt;
            core_ctrl_pkg::ALU_SRA:    o_result = $signed(i_rs1_data) >>> shamt;
            core_ctrl_pkg::ALU_OR:     o_result = i_rs1_data | op_b;
            core_ctrl_pkg::ALU_AND:    o_result = i_rs1_data & op_b;
            // LUI places the U immediate unchanged
            core_ctrl_pkg::ALU_PASS_B: o_result = op_b;
            default:                   o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/target_unit.sv */
// ---------------------------------------------------------------------------
// Second adder for jump, branch and AUIPC targets, plus branch compare.
// Targets are not checked for alignment
// ---------------------------------------------------------------------------

`default_nettype none

module target_unit (
    decode_if.exec            dec,
    input  rv_isa_pkg::word_t i_pc,
    input  rv_isa_pkg::word_t i_rs1_data,
    input  rv_isa_pkg::word_t i_rs2_data,
    output rv_isa_pkg::word_t o_target,
    output rv_isa_pkg::word_t o_link,
    output logic              o_branch_taken
);

    rv_isa_pkg::word_t sum;

    assign sum = (dec.target_from_rs1 ? i_rs1_data : i_pc) + dec.imm;

    // JALR drops bit 0 of the computed address
    assign o_target = dec.target_from_rs1 ? {sum[31:1], 1'b0} : sum;
    assign o_link   = i_pc + 32'd4;

    always_comb begin
        case (dec.branch_cond)
            rv_isa_pkg::BEQ:  o_branch_taken = (i_rs1_data == i_rs2_data);
            rv_isa_pkg::BNE:  o_branch_taken = (i_rs1_data != i_rs2_data);
            rv_isa_pkg::BLT:  o_branch_taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            rv_isa_pkg::BGE:  o_branch_taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            rv_isa_pkg::BLTU: o_branch_taken = (i_rs1_data < i_rs2_data);
            rv_isa_pkg::BGEU: o_branch_taken = (i_rs1_data >= i_rs2_data);
            // Reserved encodings fall through
            default:          o_branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/commit_unit.sv */
// ---------------------------------------------------------------------------
// PC register, write-back select and retire record. Everything updates only
// on a strobe; the retire record appears one cycle after it
// ---------------------------------------------------------------------------

`include "core_macros.svh"

`default_nettype none

module commit_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    decode_if.commit              dec,
    input  logic                  i_instr_valid,
    input  rv_isa_pkg::reg_addr_t i_rd_addr,
    input  rv_isa_pkg::word_t     i_alu_result,
    input  rv_isa_pkg::word_t     i_target,
    input  rv_isa_pkg::word_t     i_link,
    input  logic                  i_branch_taken,
    output rv_isa_pkg::word_t     o_pc,
    output logic                  o_rf_we,
    output rv_isa_pkg::word_t     o_rf_data,
    output logic                  o_retire_valid,
    output logic                  o_retire_we,
    output logic                  o_retire_illegal,
    output rv_isa_pkg::reg_addr_t o_retire_rd,
    output rv_isa_pkg::word_t     o_retire_pc,
    output rv_isa_pkg::word_t     o_retire_data
);

    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t pc_next;

    always_comb begin
        case (dec.wb_sel)
            core_ctrl_pkg::WB_LINK:   o_rf_data = i_link;
            core_ctrl_pkg::WB_TARGET: o_rf_data = i_target;
            default:                  o_rf_data = i_alu_result;
        endcase
        case (dec.pc_sel)
            core_ctrl_pkg::PC_JUMP:   pc_next = i_target;
            core_ctrl_pkg::PC_BRANCH: pc_next = i_branch_taken ? i_target : i_link;
            default:                  pc_next = i_link;
        endcase
    end

    assign o_rf_we = i_instr_valid && dec.reg_write;
    assign o_pc    = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc               <= `CORE_RESET_PC;
            o_retire_valid   <= 1'b0;
            o_retire_we      <= 1'b0;
            o_retire_illegal <= 1'b0;
        end else begin
            o_retire_valid   <= i_instr_valid;
            o_retire_we      <= o_rf_we;
            o_retire_illegal <= i_instr_valid && dec.illegal;
            if (i_instr_valid) begin
                pc <= pc_next;
            end
        end
    end

    // Retire payload, data is zero for non-writing instructions
    always_ff @(posedge clk) begin
        if (i_instr_valid) begin
            o_retire_rd   <= i_rd_addr;
            o_retire_pc   <= pc;
            o_retire_data <= dec.reg_write ? o_rf_data : '0;
        end
    end

    no_retire_without_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !i_instr_valid |=> !o_retire_valid);

endmodule

`default_nettype wire

/* verilog/holy_core.sv */
// ---------------------------------------------------------------------------
// RV32I integer core top. One instruction per strobe, no back-pressure,
// no loads, stores, CSRs or traps
// ---------------------------------------------------------------------------

`default_nettype none

module holy_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::instr_t    i_instr,
    input  logic                  i_instr_valid,
    output rv_isa_pkg::word_t     o_pc,
    output logic                  o_retire_valid,
    output logic                  o_retire_we,
    output logic                  o_retire_illegal,
    output rv_isa_pkg::reg_addr_t o_retire_rd,
    output rv_isa_pkg::word_t     o_retire_pc,
    output rv_isa_pkg::word_t     o_retire_data
);

    decode_if dec_bus ();

    rv_isa_pkg::reg_addr_t rs1_addr;
    rv_isa_pkg::reg_addr_t rs2_addr;
    rv_isa_pkg::reg_addr_t rd_addr;
    rv_isa_pkg::word_t rs1_data;
    rv_isa_pkg::word_t rs2_data;
    rv_isa_pkg::word_t alu_result;
    rv_isa_pkg::word_t target;
    rv_isa_pkg::word_t link;
    rv_isa_pkg::word_t rf_data;
    logic branch_taken;
    logic rf_we;

    // Register fields sit at fixed positions in every format
    assign rs1_addr = i_instr[19:15];
    assign rs2_addr = i_instr[24:20];
    assign rd_addr  = i_instr[11:7];

    instr_decoder u_decoder (.i_instr(i_instr), .dec(dec_bus));

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_we(rf_we), .i_rd_addr(rd_addr), .i_rd_data(rf_data)
    );

    alu u_alu (
        .dec(dec_bus), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .o_result(alu_result)
    );

    target_unit u_target (
        .dec(dec_bus), .i_pc(o_pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_target(target), .o_link(link), .o_branch_taken(branch_taken)
    );

    commit_unit u_commit (
        .clk(clk), .rst_n(rst_n), .dec(dec_bus),
        .i_instr_valid(i_instr_valid), .i_rd_addr(rd_addr),
        .i_alu_result(alu_result), .i_target(target), .i_link(link),
        .i_branch_taken(branch_taken),
        .o_pc(o_pc), .o_rf_we(rf_we), .o_rf_data(rf_data),
        .o_retire_valid(o_retire_valid), .o_retire_we(o_retire_we),
        .o_retire_illegal(o_retire_illegal), .o_retire_rd(o_retire_rd),
        .o_retire_pc(o_retire_pc), .o_retire_data(o_retire_data)
    );

endmodule

`default_nettype wire

/* tests/retire_checker.sv */
// ----------------------------------------------------------------------------
// Retire monitor. Latches the expected record at each strobe and expects
// the matching retire exactly one cycle later. rd is only checked on writes
// ----------------------------------------------------------------------------

`default_nettype none

module retire_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_instr_valid,
    input  logic [31:0] i_pc,
    input  logic        i_retire_valid,
    input  logic        i_retire_we,
    input  logic        i_retire_illegal,
    input  logic [4:0]  i_retire_rd,
    input  logic [31:0] i_retire_pc,
    input  logic [31:0] i_retire_data,
    input  int          i_exp_row,
    input  logic [31:0] i_exp_pc,
    input  logic        i_exp_we,
    input  logic [4:0]  i_exp_rd,
    input  logic [31:0] i_exp_data,
    input  logic        i_exp_illegal,
    input  logic [31:0] i_exp_next_pc,
    output int          o_tests,
    output int          o_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        pending;
    logic        reset_checked;
    int          p_row;
    logic [31:0] p_pc;
    logic        p_we;
    logic [4:0]  p_rd;
    logic [31:0] p_data;
    logic        p_ill;
    logic [31:0] p_next;
    string       test_name;
    int          bad;

    task automatic check_field(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: %s = 0x%08h, expected 0x%08h", test_name, sig, got, exp);
            bad++;
        end
    endtask

    task automatic finish_test();
        if (bad == 0) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s with %0d mismatches", test_name, bad);
            o_errors <= o_errors + 1;
        end
        o_tests <= o_tests + 1;
    endtask

    // DUT outputs are read at the edge before this edge's updates land
    always @(posedge clk) begin
        if (!rst_n) begin
            pending       <= 1'b0;
            reset_checked <= 1'b0;
            o_tests       <= 0;
            o_errors      <= 0;
        end else begin
            bad = 0;
            if (!reset_checked) begin
                test_name = "reset state";
                reset_checked <= 1'b1;
                check_field("o_pc", i_pc, 32'h0);
                check_field("o_retire_we", i_retire_we, 32'h0);
                check_field("o_retire_illegal", i_retire_illegal, 32'h0);
                if (i_retire_valid) begin
                    $display("%s: retire reported before any strobe", test_name);
                    bad++;
                end
                finish_test();
            end else if (pending) begin
                test_name = $sformatf("row %0d", p_row);
                if (!i_retire_valid) begin
                    $display("%s: no retire one cycle after its strobe", test_name);
                    bad++;
                end else begin
                    check_field("o_retire_pc", i_retire_pc, p_pc);
                    check_field("o_retire_we", i_retire_we, p_we);
                    if (p_we) begin
                        check_field("o_retire_rd", i_retire_rd, p_rd);
                    end
                    check_field("o_retire_data", i_retire_data, p_data);
                    check_field("o_retire_illegal", i_retire_illegal, p_ill);
                    check_field("o_pc", i_pc, p_next);
                end
                finish_test();
            end else if (i_retire_valid) begin
                $display("Unexpected retire at pc 0x%08h without a strobe the cycle before",
                         i_retire_pc);
                o_errors <= o_errors + 1;
            end

            pending <= i_instr_valid;
            if (i_instr_valid) begin
                p_row  <= i_exp_row;
                p_pc   <= i_exp_pc;
                p_we   <= i_exp_we;
                p_rd   <= i_exp_rd;
                p_data <= i_exp_data;
                p_ill  <= i_exp_illegal;
                p_next <= i_exp_next_pc;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_holy_core.sv */
// ----------------------------------------------------------------------------
// Runs a fixed RV32I program through the core with one table row per strobe.
// Rows follow the executed path, so taken branches and jumps skip ahead
// ----------------------------------------------------------------------------

`default_nettype none

module tb_holy_core;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [31:0] instr;
        int          gap;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        ill;
        logic [31:0] next_pc;
    } step_t;

    step_t steps[$];

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic [31:0] pc;
    logic        retire_valid;
    logic        retire_we;
    logic        retire_illegal;
    logic [4:0]  retire_rd;
    logic [31:0] retire_pc;
    logic [31:0] retire_data;

    int          exp_row;
    logic [31:0] exp_pc;
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_ill;
    logic [31:0] exp_next;
    logic [31:0] trace_pc;
    int          tests;
    int          errors;
    int          cycles;
    int          limit;

    always #4 clk = ~clk;

    holy_core UUT (
        .clk(clk), .rst_n(rst_n), .i_instr(instr), .i_instr_valid(instr_valid),
        .o_pc(pc), .o_retire_valid(retire_valid), .o_retire_we(retire_we),
        .o_retire_illegal(retire_illegal), .o_retire_rd(retire_rd),
        .o_retire_pc(retire_pc), .o_retire_data(retire_data)
    );

    retire_checker u_checker (
        .clk(clk), .rst_n(rst_n), .i_instr_valid(instr_valid), .i_pc(pc),
        .i_retire_valid(retire_valid), .i_retire_we(retire_we),
        .i_retire_illegal(retire_illegal), .i_retire_rd(retire_rd),
        .i_retire_pc(retire_pc), .i_retire_data(retire_data),
        .i_exp_row(exp_row), .i_exp_pc(exp_pc), .i_exp_we(exp_we), .i_exp_rd(exp_rd),
        .i_exp_data(exp_data), .i_exp_illegal(exp_ill), .i_exp_next_pc(exp_next),
        .o_tests(tests), .o_errors(errors)
    );

    // Offsets and immediates of the encoders are two's complement
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input int rs2,
                                             input int rs1, input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input int imm, input int rs1, input logic [2:0] f3,
                                             input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input int rd,
                                             input logic [6:0] opc);
        return {imm, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encode_b(input int off, input int rs2, input int rs1,
                                             input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic add_step(input logic [31:0] ins, input int gap, input logic we,
                            input int rd, input logic [31:0] data, input logic ill,
                            input logic [31:0] next_pc);
        step_t s;
        s.instr   = ins;
        s.gap     = gap;
        s.we      = we;
        s.rd      = rd[4:0];
        s.data    = data;
        s.ill     = ill;
        s.next_pc = next_pc;
        steps.push_back(s);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        exp_row     = 0;
        exp_pc      = '0;
        exp_we      = 1'b0;
        exp_rd      = '0;
        exp_data    = '0;
        exp_ill     = 1'b0;
        exp_next    = '0;
        trace_pc    = '0;
        cycles      = 0;

        // ALU operations on x1 = -5 and x2 = 3 followed by LUI and AUIPC
        add_step(encode_i(-5, 0, 3'b000, 1, 7'b0010011), 2, 1, 1, 32'hffff_fffb, 0, 4);
        add_step(encode_i(3, 0, 3'b000, 2, 7'b0010011), 0, 1, 2, 32'h3, 0, 8);
        add_step(encode_r(7'h00, 2, 1, 3'b010, 3), 0, 1, 3, 32'h1, 0, 12);
        add_step(encode_r(7'h00, 2, 1, 3'b011, 4), 1, 1, 4, 32'h0, 0, 16);
        add_step(encode_i(32'h401, 1, 3'b101, 5, 7'b0010011), 0, 1, 5, 32'hffff_fffd, 0, 20);
        add_step(encode_i(4, 1, 3'b101, 6, 7'b0010011), 0, 1, 6, 32'h0fff_ffff, 0, 24);
        add_step(encode_r(7'h20, 1, 2, 3'b000, 7), 0, 1, 7, 32'h8, 0, 28);
        add_step(encode_r(7'h20, 2, 1, 3'b101, 8), 0, 1, 8, 32'hffff_ffff, 0, 32);
        add_step(encode_r(7'h00, 2, 2, 3'b001, 9), 0, 1, 9, 32'h18, 0, 36);
        add_step(encode_r(7'h00, 2, 1, 3'b100, 10), 0, 1, 10, 32'hffff_fff8, 0, 40);
        add_step(encode_r(7'h00, 2, 1, 3'b111, 11), 0, 1, 11, 32'h3, 0, 44);
        add_step(encode_i(-4, 1, 3'b010, 12, 7'b0010011), 0, 1, 12, 32'h1, 0, 48);
        add_step(encode_i(-1, 2, 3'b011, 13, 7'b0010011), 0, 1, 13, 32'h1, 0, 52);
        add_step(encode_i(32'h100, 2, 3'b110, 14, 7'b0010011), 0, 1, 14, 32'h103, 0, 56);
        add_step(encode_u(20'h12345, 15, 7'b0110111), 0, 1, 15, 32'h1234_5000, 0, 60);
        add_step(encode_u(20'h00001, 16, 7'b0010111), 0, 1, 16, 32'h103c, 0, 64);
        // Write to x0 is reported but must not stick
        add_step(encode_i(7, 2, 3'b000, 0, 7'b0010011), 0, 1, 0, 32'ha, 0, 68);
        add_step(encode_r(7'h00, 2, 0, 3'b000, 17), 2, 1, 17, 32'h3, 0, 72);
        // Branches of all six conditions
        add_step(encode_b(8, 2, 2, 3'b000), 0, 0, 0, 32'h0, 0, 80);
        add_step(encode_b(8, 2, 2, 3'b001), 0, 0, 0, 32'h0, 0, 84);
        add_step(encode_b(8, 2, 1, 3'b100), 0, 0, 0, 32'h0, 0, 92);
        add_step(encode_b(8, 2, 1, 3'b101), 0, 0, 0, 32'h0, 0, 96);
        add_step(encode_b(8, 2, 1, 3'b110), 0, 0, 0, 32'h0, 0, 100);
        add_step(encode_b(-16, 2, 1, 3'b111), 0, 0, 0, 32'h0, 0, 84);
        add_step(encode_b(16, 2, 1, 3'b001), 0, 0, 0, 32'h0, 0, 100);
        // Jumps where the JALR sum 3 + 0x3e has bit 0 set
        add_step(encode_j(12, 18), 0, 1, 18, 32'h68, 0, 112);
        add_step(encode_i(32'h3e, 2, 3'b000, 19, 7'b1100111), 0, 1, 19, 32'h74, 0, 64);
        // A load is not supported, so it retires as illegal and leaves x3 alone
        add_step(encode_i(4, 1, 3'b010, 3, 7'b0000011), 0, 0, 3, 32'h0, 1, 68);
        add_step(encode_r(7'h00, 18, 3, 3'b000, 20), 3, 1, 20, 32'h69, 0, 72);
        add_step(encode_j(-72, 0), 0, 1, 0, 32'h4c, 0, 0);
        add_step(encode_i(32'hf0, 19, 3'b100, 21, 7'b0010011), 0, 1, 21, 32'h84, 0, 4);
        // Each condition again in its other direction
        add_step(encode_b(8, 2, 1, 3'b000), 0, 0, 0, 32'h0, 0, 8);
        add_step(encode_b(8, 1, 2, 3'b100), 0, 0, 0, 32'h0, 0, 12);
        add_step(encode_b(8, 1, 2, 3'b101), 0, 0, 0, 32'h0, 0, 20);
        add_step(encode_b(8, 1, 2, 3'b110), 0, 0, 0, 32'h0, 0, 28);
        add_step(encode_b(8, 1, 2, 3'b111), 0, 0, 0, 32'h0, 0, 32);

        limit = 8 + 20;
        foreach (steps[i]) begin
            limit += steps[i].gap + 2;
        end

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        foreach (steps[i]) begin
            instr_valid = 1'b0;
            repeat (steps[i].gap) @(negedge clk);
            instr       = steps[i].instr;
            exp_row     = i;
            exp_pc      = trace_pc;
            exp_we      = steps[i].we;
            exp_rd      = steps[i].rd;
            exp_data    = steps[i].data;
            exp_ill     = steps[i].ill;
            exp_next    = steps[i].next_pc;
            instr_valid = 1'b1;
            trace_pc    = steps[i].next_pc;
            @(negedge clk);
        end
        instr_valid = 1'b0;

        // Reset check plus one test per row
        while (tests < steps.size() + 1) @(posedge clk);
        repeat (2) @(posedge clk);

        $display("Tests run: %0d, failed: %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, not every instruction retired", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/decode_if.sv
verilog/instr_decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/target_unit.sv
verilog/commit_unit.sv
verilog/holy_core.sv
tests/retire_checker.sv
tests/tb_holy_core.sv
